//--- verilog.f
+incdir+rtl
rtl/stepper_cmd_pkg.sv
rtl/cmd_fifo_if.sv
rtl/spi_word_rx.sv
rtl/cmd_fifo.sv
rtl/step_executor.sv
rtl/stepper_cmd_top.sv
bench/tb_stepper_cmd.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_stepper_cmd
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_stepper_cmd.sv
`timescale 1ns/1ps
`default_nettype none

`include "stepper_cmd_cfg.svh"

module tb_stepper_cmd;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic step;
  logic dir;
  logic en;
  logic move_done;
  logic buffer_ready;
  logic overrun;

  integer seed;
  integer r;
  int     mismatch_cnt = 0;
  int     fail_cnt = 0;     // Timeouts and protocol failures
  int     cycle = 0;
  int     last_step_cycle = 0;
  int     step_cnt = 0;     // Steps seen in the running move
  int     total_steps = 0;
  int     moves_done = 0;
  int     moves_expected = 0;
  logic   moving;
  logic   hold_en_low;
  int     exp_steps [$];
  logic   exp_dir [$];

  stepper_cmd_top u_stepper_cmd_top (
    .CLK          (CLK),
    .resetn       (resetn),
    .sck          (sck),
    .cs           (cs),
    .copi         (copi),
    .step         (step),
    .dir          (dir),
    .en           (en),
    .move_done    (move_done),
    .buffer_ready (buffer_ready),
    .overrun      (overrun)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  a_step_single: assert property (@(posedge CLK) disable iff (!resetn) step |=> !step)
    else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: step high in two consecutive cycles", $time);
    end

  a_dir_stable: assert property (@(posedge CLK) disable iff (!resetn) moving |-> $stable(dir))
    else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: dir changed during a move", $time);
    end

  a_overrun_sticky: assert property (@(posedge CLK) disable iff (!resetn) overrun |=> overrun)
    else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: overrun fell without reset", $time);
    end

  a_en_held: assert property (@(posedge CLK) disable iff (!resetn) hold_en_low |-> !en)
    else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: en rose after an aborted word", $time);
    end

  // Step and move_done scoreboard
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (!resetn) begin
      moving <= 1'b0;
    end else begin
      if (step) begin
        if (exp_dir.size() == 0) begin
          fail_cnt = fail_cnt + 1;
          $display("Step pulse at %0t while no move was expected", $time);
        end else begin
          assert (dir == exp_dir[0]) else begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("mismatch at %0t: dir %0b at step, expected %0b", $time, dir, exp_dir[0]);
          end
        end
        if (moving) begin
          assert (cycle - last_step_cycle >= `STEP_PERIOD) else begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("mismatch at %0t: steps only %0d cycles apart", $time,
                     cycle - last_step_cycle);
          end
        end
        last_step_cycle = cycle;
        step_cnt = step_cnt + 1;
        total_steps = total_steps + 1;
        moving <= 1'b1;
      end
      if (move_done) begin
        if (exp_steps.size() == 0) begin
          fail_cnt = fail_cnt + 1;
          $display("move_done pulse at %0t while no move was expected", $time);
        end else begin
          assert (step_cnt == exp_steps[0]) else begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("mismatch at %0t: %0d step pulses, expected %0d", $time, step_cnt,
                     exp_steps[0]);
          end
          void'(exp_steps.pop_front());
          void'(exp_dir.pop_front());
        end
        step_cnt = 0;
        moves_done = moves_done + 1;
        moving <= 1'b0;
      end
    end
  end

  task automatic check_bit(input logic got, input logic expected, input string what);
    assert (got === expected) else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  task automatic check_count(input int got, input int expected, input string what);
    assert (got == expected) else begin
      mismatch_cnt = mismatch_cnt + 1;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // SPI mode 0 at CLK/4, LSB byte first, MSB bit first
  task automatic send_bits(input logic [63:0] word, input int nbits);
    logic [5:0] idx;
    int         k;
    @(negedge CLK);
    cs = 1'b0;
    for (k = 0; k < nbits; k++) begin
      idx = 6'((k / 8) * 8 + 7 - (k % 8));
      @(negedge CLK);
      sck  = 1'b0;
      copi = word[idx];
      @(negedge CLK);
      @(negedge CLK);
      sck = 1'b1;
      @(negedge CLK);
    end
  endtask

  task automatic send_word(input logic [63:0] word);
    send_bits(word, 64);
  endtask

  task automatic end_burst();
    @(negedge CLK);
    sck = 1'b0;
    repeat (4) @(negedge CLK);
    cs = 1'b1;
    repeat (4) @(negedge CLK);
  endtask

  task automatic send_move(input logic d, input logic [31:0] count);
    send_word({`OP_MOVE, 55'd0, d});
    send_word({32'd0, count});
  endtask

  task automatic expect_move(input logic d, input int n);
    exp_steps.push_back(n);
    exp_dir.push_back(d);
    moves_expected = moves_expected + 1;
  endtask

  task automatic wait_moves(input int target, input int limit);
    int n;
    n = 0;
    while (moves_done < target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (moves_done < target) begin
      fail_cnt = fail_cnt + 1;
      $display("Timeout at %0t waiting for move_done number %0d", $time, target);
    end
  endtask

  task automatic wait_en(input logic level, input int limit);
    int n;
    n = 0;
    while (en !== level && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (en !== level) begin
      fail_cnt = fail_cnt + 1;
      $display("Timeout at %0t waiting for en to become %0b", $time, level);
    end
  endtask

  initial begin
    int   n;
    logic d;
    int   base_moves;
    int   base_steps;
    seed        = 50500;
    resetn      = 1'b0;
    sck         = 1'b0;
    cs          = 1'b1;
    copi        = 1'b0;
    hold_en_low = 1'b0;
    repeat (8) @(negedge CLK);
    resetn = 1'b1;
    repeat (4) @(negedge CLK);

    check_bit(step, 1'b0, "step after reset");
    check_bit(move_done, 1'b0, "move_done after reset");
    check_bit(en, 1'b0, "en after reset");
    check_bit(overrun, 1'b0, "overrun after reset");
    check_bit(buffer_ready, 1'b1, "buffer_ready after reset");

    send_word(64'h0a00_0000_0000_0001);
    end_burst();
    wait_en(1'b1, 300);

    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      n = $unsigned(r) % 40 + 1;
      r = $random(seed);
      d = r[0];
      expect_move(d, n);
      send_move(d, n);
      end_burst();
      wait_moves(moves_expected, n * `STEP_PERIOD + 300);
    end

    expect_move(1'b1, 0);    // Zero count while enabled
    send_move(1'b1, 32'd0);
    end_burst();
    wait_moves(moves_expected, 300);

    base_moves = moves_done;
    send_word(64'h0a00_0000_0000_0000);
    end_burst();
    wait_en(1'b0, 300);
    repeat (20) @(negedge CLK);
    check_count(moves_done, base_moves, "move_done pulses after disable");

    expect_move(1'b0, 0);    // No steps while disabled
    send_move(1'b0, 32'd10);
    end_burst();
    wait_moves(moves_expected, 300);

    send_word(64'h0a00_0000_0000_0001);
    end_burst();
    wait_en(1'b1, 300);
    expect_move(1'b1, 1000);
    expect_move(1'b0, 2);
    expect_move(1'b0, 2);
    send_move(1'b1, 32'd1000);
    send_move(1'b0, 32'd2);
    send_move(1'b0, 32'd2);
    send_move(1'b1, 32'd2);  // Lands on a full FIFO
    end_burst();
    check_bit(buffer_ready, 1'b0, "buffer_ready with full FIFO");
    check_bit(overrun, 1'b1, "overrun after dropped words");
    wait_moves(moves_expected - 2, 1000 * `STEP_PERIOD + 500);
    base_steps = total_steps;
    wait_moves(moves_expected, 300);
    repeat (200) @(negedge CLK);
    check_count(total_steps - base_steps, 4, "steps of the buffered moves");
    check_count(moves_done, moves_expected, "move_done pulses after overrun");
    check_bit(buffer_ready, 1'b1, "buffer_ready after drain");

    send_word(64'h0a00_0000_0000_0000);
    end_burst();
    wait_en(1'b0, 300);
    hold_en_low = 1'b1;
    base_moves  = moves_done;
    base_steps  = total_steps;
    send_bits(64'h0a00_0000_0000_0001, 20);
    end_burst();
    send_word(64'h0a00_0000_0000_0000);
    end_burst();
    repeat (100) @(negedge CLK);
    check_count(moves_done, base_moves, "move_done pulses after aborted word");
    check_count(total_steps, base_steps, "steps after aborted word");
    hold_en_low = 1'b0;

    send_word(64'h0a00_0000_0000_0001);  // Word framing intact after the abort
    end_burst();
    wait_en(1'b1, 300);

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/stepper_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_cmd_top (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic step,
  output logic dir,
  output logic en,
  output logic move_done,
  output logic buffer_ready,
  output logic overrun
);

  cmd_fifo_if fifo_bus ();

  spi_word_rx u_rx (
    .CLK     (CLK),
    .resetn  (resetn),
    .sck     (sck),
    .cs      (cs),
    .copi    (copi),
    .overrun (overrun),
    .fifo_w  (fifo_bus.writer)
  );

  cmd_fifo u_fifo (
    .CLK    (CLK),
    .resetn (resetn),
    .port   (fifo_bus.fifo)
  );

  step_executor u_exec (
    .CLK       (CLK),
    .resetn    (resetn),
    .fifo_r    (fifo_bus.reader),
    .step      (step),
    .dir       (dir),
    .en        (en),
    .move_done (move_done)
  );

  assign buffer_ready = !fifo_bus.full;  // Host may send another word

endmodule

`default_nettype wire

//--- rtl/step_executor.sv
`timescale 1ns/1ps
`default_nettype none

`include "stepper_cmd_cfg.svh"

module step_executor (
  input  logic CLK,
  input  logic resetn,
  cmd_fifo_if.reader fifo_r,
  output logic step,
  output logic dir,
  output logic en,
  output logic move_done
);

  stepper_cmd_pkg::exec_state_t state;
  stepper_cmd_pkg::opcode_t     opcode;
  stepper_cmd_pkg::step_count_t steps_left;
  stepper_cmd_pkg::step_count_t count_in;

  logic [$clog2(`STEP_PERIOD)-1:0] period_cnt;

  logic take_word;
  logic last_step;

  assign opcode   = fifo_r.rd_word[63:56];
  assign count_in = fifo_r.rd_word[31:0];

  // Only the header and count states consume words
  assign take_word = !fifo_r.empty &&
                     ((state == stepper_cmd_pkg::EXEC_IDLE) ||
                      (state == stepper_cmd_pkg::EXEC_ARG));
  assign fifo_r.pop = take_word;

  assign step      = (state == stepper_cmd_pkg::EXEC_RUN) && (period_cnt == '0);
  assign last_step = step && (steps_left == 32'd1);
  assign move_done = (state == stepper_cmd_pkg::EXEC_DONE);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state      <= stepper_cmd_pkg::EXEC_IDLE;
      en         <= 1'b0;
      dir        <= 1'b0;
      steps_left <= '0;
      period_cnt <= '0;
    end else begin
      case (state)
        stepper_cmd_pkg::EXEC_IDLE: begin
          if (take_word) begin
            if (opcode == `OP_ENABLE) begin
              en <= fifo_r.rd_word[0];
            end else if (opcode == `OP_MOVE) begin
              dir   <= fifo_r.rd_word[0];  // Held until the next move header
              state <= stepper_cmd_pkg::EXEC_ARG;
            end
            // Anything else is dropped
          end
        end

        stepper_cmd_pkg::EXEC_ARG: begin
          if (take_word) begin
            steps_left <= count_in;
            period_cnt <= '0;
            if (count_in == '0 || !en) begin
              state <= stepper_cmd_pkg::EXEC_DONE;
            end else begin
              state <= stepper_cmd_pkg::EXEC_RUN;
            end
          end
        end

        stepper_cmd_pkg::EXEC_RUN: begin
          if (period_cnt == ($clog2(`STEP_PERIOD))'(`STEP_PERIOD - 1)) begin
            period_cnt <= '0;
          end else begin
            period_cnt <= period_cnt + 1'b1;
          end
          if (step) begin
            steps_left <= steps_left - 32'd1;
          end
          if (last_step) begin
            state <= stepper_cmd_pkg::EXEC_DONE;
          end
        end

        stepper_cmd_pkg::EXEC_DONE: begin
          state <= stepper_cmd_pkg::EXEC_IDLE;
        end

        default: begin
          state <= stepper_cmd_pkg::EXEC_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "stepper_cmd_cfg.svh"

module cmd_fifo (
  input  logic CLK,
  input  logic resetn,
  cmd_fifo_if.fifo port
);

  stepper_cmd_pkg::cmd_word_t mem [`CMD_FIFO_DEPTH];

  stepper_cmd_pkg::fifo_ptr_t wr_ptr;
  stepper_cmd_pkg::fifo_ptr_t rd_ptr;

  logic do_write;

  assign do_write = port.push && !port.full;  // Push while full is lost

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (port.pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (do_write) begin
      mem[wr_ptr[`CMD_FIFO_AW-1:0]] <= port.wr_word;
    end
  end

  // Same slot, different lap means full
  assign port.empty = (wr_ptr == rd_ptr);
  assign port.full  = (wr_ptr == {~rd_ptr[`CMD_FIFO_AW], rd_ptr[`CMD_FIFO_AW-1:0]});

  assign port.rd_word = mem[rd_ptr[`CMD_FIFO_AW-1:0]];  // Head, first word fall through

endmodule

`default_nettype wire

//--- rtl/spi_word_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_word_rx (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic overrun,
  cmd_fifo_if.writer fifo_w
);

  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_d;

  logic       sck_rise;
  logic       bit_take;
  logic       byte_end;
  logic       word_end;

  logic [2:0] bit_cnt;   // Bit within the byte
  logic [2:0] byte_cnt;  // Byte within the word
  logic [6:0] byte_sr;
  logic       push_q;

  stepper_cmd_pkg::cmd_word_t word_q;

  // Two-flop synchronizers plus edge history for SCK
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= 2'b00;
      cs_sync   <= 2'b11;  // Deselected
      copi_sync <= 2'b00;
      sck_d     <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      cs_sync   <= {cs_sync[0], cs};
      copi_sync <= {copi_sync[0], copi};
      sck_d     <= sck_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] && !sck_d;
  assign bit_take = sck_rise && !cs_sync[1];
  assign byte_end = bit_take && (bit_cnt == 3'd7);
  assign word_end = byte_end && (byte_cnt == 3'd7);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      push_q   <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      push_q <= 1'b0;
      if (cs_sync[1]) begin
        bit_cnt  <= '0;  // Drop any partial word
        byte_cnt <= '0;
      end else if (bit_take) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (byte_end) begin
          byte_cnt <= byte_cnt + 3'd1;
        end
        if (word_end) begin
          if (fifo_w.full) begin
            overrun <= 1'b1;  // Sticky until reset
          end else begin
            push_q <= 1'b1;
          end
        end
      end
    end
  end

  // Bytes arrive MSB first, LSB byte of the word first
  always_ff @(posedge CLK) begin
    if (bit_take) begin
      byte_sr <= {byte_sr[5:0], copi_sync[1]};
      if (byte_end) begin
        word_q[{byte_cnt, 3'b000} +: 8] <= {byte_sr, copi_sync[1]};
      end
    end
  end

  assign fifo_w.push    = push_q;
  assign fifo_w.wr_word = word_q;

endmodule

`default_nettype wire

//--- rtl/cmd_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cmd_fifo_if;

  logic                       push;
  stepper_cmd_pkg::cmd_word_t wr_word;
  logic                       full;
  logic                       pop;
  stepper_cmd_pkg::cmd_word_t rd_word;
  logic                       empty;

  modport writer (
    output push,
    output wr_word,
    input  full
  );

  modport reader (
    output pop,
    input  rd_word,
    input  empty
  );

  modport fifo (
    input  push,
    input  wr_word,
    input  pop,
    output full,
    output empty,
    output rd_word
  );

endinterface

`default_nettype wire

//--- rtl/stepper_cmd_pkg.sv
`default_nettype none

`include "stepper_cmd_cfg.svh"

package stepper_cmd_pkg;

  typedef logic [63:0] cmd_word_t;   // One SPI command word
  typedef logic [7:0]  opcode_t;     // Byte 7 of a header
  typedef logic [31:0] step_count_t; // Low half of a count word

  // Extra bit tells full from empty
  typedef logic [`CMD_FIFO_AW:0] fifo_ptr_t;

  typedef enum logic [1:0] {
    EXEC_IDLE,  // Waiting for a header
    EXEC_ARG,   // Waiting for the count word of a move
    EXEC_RUN,   // Issuing step pulses
    EXEC_DONE   // One cycle of move_done
  } exec_state_t;

endpackage

`default_nettype wire

//--- rtl/stepper_cmd_cfg.svh
`ifndef STEPPER_CMD_CFG_SVH
`define STEPPER_CMD_CFG_SVH

// Command FIFO geometry
`define CMD_FIFO_DEPTH 4
`define CMD_FIFO_AW    2

`define STEP_PERIOD 16   // CLK cycles between step pulses

// Command opcodes, byte 7 of a header word
`define OP_ENABLE 8'h0a
`define OP_MOVE   8'h01

`endif
